// ==== dm_abstract_cmd.sv ====
// **************************************************
// runs 32-bit access memory reads only
// memory must return instr_i one cycle after pc_o moves
// **************************************************
`timescale 1ns/1ps
`include "dm_settings.svh"

module dm_abstract_cmd
(
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   cmd_start_i,
    input  dm_pkg::dm_access_mem_t cmd_i,
    input  logic [`DM_WORD_W-1:0]  data1_i,
    input  logic [`DM_WORD_W-1:0]  instr_i,
    output logic [`DM_WORD_W-1:0]  pc_o,
    output dm_pkg::dm_data0_upd_t  data0_upd_o
);

    logic                  supported;
    logic                  launch;
    // memory word due on instr_i this cycle
    logic                  pending_q;
    logic [`DM_WORD_W-1:0] pc_q;

    // access memory, read direction, 32-bit size
    // virtual and postincrement bits are not looked at
    assign supported = (cmd_i.cmdtype == `DM_CMDTYPE_ACCESS_MEM)
                    && !cmd_i.aamwrite
                    && (cmd_i.aamsize == `DM_AAMSIZE_32);

    // other commands are dropped without a trace
    assign launch = cmd_start_i && supported;

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            pc_q      <= '0;
            pending_q <= 1'b0;
        end
        else
        begin
            pending_q <= launch;
            if (launch)
            begin
                // address is taken from data1
                pc_q <= data1_i;
            end
        end
    end

    assign pc_o = pc_q;

    // returned word goes straight to data0 on the next edge
    always_comb
    begin
        data0_upd_o.valid = pending_q;
        data0_upd_o.value = instr_i;
    end

endmodule

// ==== dm_pkg.sv ====
// **************************************************
// structs shared by the debug module blocks
// command layout is the access memory format only
// **************************************************
`include "dm_settings.svh"

package dm_pkg;

    // one wishbone request as seen by the slave
    typedef struct packed {
        logic [`DM_ADDR_W-1:0] addr;
        logic                  we;
        logic [`DM_BUS_DW-1:0] wdata;
        logic                  cyc;
        logic                  stb;
    } dm_wb_req_t;

    // register write strobe, valid for one cycle per transaction
    typedef struct packed {
        logic                  valid;
        logic [`DM_ADDR_W-1:0] addr;
        logic [`DM_BUS_DW-1:0] data;
    } dm_reg_wr_t;

    // access memory command word, msb first
    // a 32-bit memory read encodes as 0x0220_0000
    typedef struct packed {
        // 0x02 selects access memory
        logic [7:0]  cmdtype;
        logic        aamvirtual;
        // 2 means a 32-bit access
        logic [2:0]  aamsize;
        logic        aampostincrement;
        logic [1:0]  rsvd;
        // 0 reads memory, 1 writes it
        logic        aamwrite;
        logic [1:0]  target_specific;
        logic [13:0] rsvd_low;
    } dm_access_mem_t;

    // data0 update from the abstract command unit
    typedef struct packed {
        logic                  valid;
        logic [`DM_WORD_W-1:0] value;
    } dm_data0_upd_t;

endpackage

// ==== dm_regs.sv ====
// **************************************************
// data0, data1, dmcontrol and command registers
// a command result beats a bus write to data0 on one edge
// **************************************************
`timescale 1ns/1ps
`include "dm_settings.svh"

module dm_regs
(
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  dm_pkg::dm_reg_wr_t     reg_wr_i,
    input  logic [`DM_ADDR_W-1:0]  rd_addr_i,
    output logic [`DM_BUS_DW-1:0]  rd_data_o,
    input  dm_pkg::dm_data0_upd_t  data0_upd_i,
    output logic                   cmd_start_o,
    output dm_pkg::dm_access_mem_t cmd_o,
    output logic [`DM_WORD_W-1:0]  data1_o,
    output logic                   halt_req_o,
    output logic                   resume_req_o
);

    // data0 and command are 32 bits wide, read back zero extended
    logic [`DM_WORD_W-1:0] data0_q;
    logic [`DM_BUS_DW-1:0] data1_q;
    logic [`DM_BUS_DW-1:0] dmcontrol_q;
    logic [`DM_WORD_W-1:0] command_q;
    logic                  cmd_start_q;

    // write address decode
    logic wr_data0;
    logic wr_data1;
    logic wr_dmcontrol;
    logic wr_command;

    assign wr_data0     = reg_wr_i.valid && (reg_wr_i.addr == `DM_ADDR_DATA0);
    assign wr_data1     = reg_wr_i.valid && (reg_wr_i.addr == `DM_ADDR_DATA1);
    assign wr_dmcontrol = reg_wr_i.valid && (reg_wr_i.addr == `DM_ADDR_DMCONTROL);
    assign wr_command   = reg_wr_i.valid && (reg_wr_i.addr == `DM_ADDR_COMMAND);

    // data0 has two sources
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            data0_q <= '0;
        end
        else if (data0_upd_i.valid)
        begin
            // memory read result
            data0_q <= data0_upd_i.value;
        end
        else if (wr_data0)
        begin
            // only the low word of the bus is kept
            data0_q <= reg_wr_i.data[`DM_WORD_W-1:0];
        end
    end

    // bus only registers
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            data1_q     <= '0;
            dmcontrol_q <= '0;
            command_q   <= '0;
        end
        else
        begin
            if (wr_data1)
            begin
                data1_q <= reg_wr_i.data;
            end
            if (wr_dmcontrol)
            begin
                dmcontrol_q <= reg_wr_i.data;
            end
            if (wr_command)
            begin
                command_q <= reg_wr_i.data[`DM_WORD_W-1:0];
            end
        end
    end

    // start pulse comes one cycle after the command write,
    // when command_q already holds the new word
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            cmd_start_q <= 1'b0;
        end
        else
        begin
            cmd_start_q <= wr_command;
        end
    end

    // read mux, unknown addresses read zero
    always_comb
    begin
        case (rd_addr_i)
            `DM_ADDR_DATA0:
            begin
                rd_data_o = {{(`DM_BUS_DW-`DM_WORD_W){1'b0}}, data0_q};
            end
            `DM_ADDR_DATA1:
            begin
                rd_data_o = data1_q;
            end
            `DM_ADDR_DMCONTROL:
            begin
                rd_data_o = dmcontrol_q;
            end
            `DM_ADDR_COMMAND:
            begin
                rd_data_o = {{(`DM_BUS_DW-`DM_WORD_W){1'b0}}, command_q};
            end
            default:
            begin
                rd_data_o = '0;
            end
        endcase
    end

    assign cmd_start_o = cmd_start_q;
    assign cmd_o       = dm_pkg::dm_access_mem_t'(command_q);
    // address operand of the memory access
    assign data1_o     = data1_q[`DM_WORD_W-1:0];

    // run control requests leave as levels
    assign halt_req_o   = dmcontrol_q[`DM_HALTREQ_BIT];
    assign resume_req_o = dmcontrol_q[`DM_RESUMEREQ_BIT];

endmodule

// ==== dm_settings.svh ====
// **************************************************
// widths and register map of the debug module
// only four dm registers exist, any other address reads zero
// **************************************************
`ifndef DM_SETTINGS_SVH
`define DM_SETTINGS_SVH

// wishbone bus and memory word widths
`define DM_BUS_DW              64
`define DM_ADDR_W              32
`define DM_WORD_W              32

// dm register addresses, word addressed
`define DM_ADDR_DATA0          32'h0000_0004
`define DM_ADDR_DATA1          32'h0000_0005
`define DM_ADDR_DMCONTROL      32'h0000_0010
`define DM_ADDR_COMMAND        32'h0000_0017

// dmcontrol bit positions
`define DM_HALTREQ_BIT         31
`define DM_RESUMEREQ_BIT       30

// abstract command encodings
`define DM_CMDTYPE_ACCESS_MEM  8'h02
`define DM_AAMSIZE_32          3'd2

`endif

// ==== dm_top.sv ====
// **************************************************
// debug module with a 64-bit wishbone classic slave port
// pc_o and instr_i form a one cycle memory read path
// **************************************************
`timescale 1ns/1ps
`include "dm_settings.svh"

module dm_top
(
    input  logic                  clk_i,
    input  logic                  rst_i,
    // wishbone slave pins
    input  logic [`DM_ADDR_W-1:0] addr_i,
    input  logic                  we_i,
    input  logic [`DM_BUS_DW-1:0] data_i,
    input  logic                  cyc_i,
    input  logic                  stb_i,
    // memory read return
    input  logic [`DM_WORD_W-1:0] instr_i,
    output logic [`DM_BUS_DW-1:0] data_o,
    output logic                  ack_o,
    // memory read address
    output logic [`DM_WORD_W-1:0] pc_o,
    output logic                  halt_req_o,
    output logic                  resume_req_o
);

    dm_pkg::dm_wb_req_t     wb_req;
    dm_pkg::dm_reg_wr_t     reg_wr;
    dm_pkg::dm_data0_upd_t  data0_upd;
    dm_pkg::dm_access_mem_t cmd;
    logic [`DM_ADDR_W-1:0]  rd_addr;
    logic [`DM_BUS_DW-1:0]  rd_data;
    logic [`DM_WORD_W-1:0]  data1;
    logic                   cmd_start;

    // bundle the bus pins
    assign wb_req = '{addr: addr_i, we: we_i, wdata: data_i, cyc: cyc_i, stb: stb_i};

    dm_wb_slave u_wb_slave (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .wb_req_i  (wb_req),
        .rd_addr_o (rd_addr),
        .rd_data_i (rd_data),
        .reg_wr_o  (reg_wr),
        .ack_o     (ack_o),
        .data_o    (data_o)
    );

    dm_regs u_regs (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .reg_wr_i     (reg_wr),
        .rd_addr_i    (rd_addr),
        .rd_data_o    (rd_data),
        .data0_upd_i  (data0_upd),
        .cmd_start_o  (cmd_start),
        .cmd_o        (cmd),
        .data1_o      (data1),
        .halt_req_o   (halt_req_o),
        .resume_req_o (resume_req_o)
    );

    dm_abstract_cmd u_abstract_cmd (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .cmd_start_i (cmd_start),
        .cmd_i       (cmd),
        .data1_i     (data1),
        .instr_i     (instr_i),
        .pc_o        (pc_o),
        .data0_upd_o (data0_upd)
    );

endmodule

// ==== dm_wb_slave.sv ====
// **************************************************
// wishbone classic slave, no wait states after ack
// master must hold cyc and stb until ack is seen
// **************************************************
`timescale 1ns/1ps
`include "dm_settings.svh"

module dm_wb_slave
(
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  dm_pkg::dm_wb_req_t    wb_req_i,
    output logic [`DM_ADDR_W-1:0] rd_addr_o,
    input  logic [`DM_BUS_DW-1:0] rd_data_i,
    output dm_pkg::dm_reg_wr_t    reg_wr_o,
    output logic                  ack_o,
    output logic [`DM_BUS_DW-1:0] data_o
);

    // slave states
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_READ  = 2'd1,
        ST_WRITE = 2'd2
    } state_t;

    state_t                state_q;
    // set once the write of this transaction went out
    logic                  done_q;
    logic                  ack_q;
    logic [`DM_BUS_DW-1:0] data_q;
    // transaction still held by the master
    logic                  active;
    // both strobes high starts a transaction
    logic                  start;

    assign active = wb_req_i.cyc | wb_req_i.stb;
    assign start  = wb_req_i.cyc & wb_req_i.stb;

    // the addressed register is looked up in both states
    assign rd_addr_o = wb_req_i.addr;

    // write strobe lines up with the edge that raises ack
    always_comb
    begin
        reg_wr_o.valid = (state_q == ST_WRITE) && active && !done_q;
        reg_wr_o.addr  = wb_req_i.addr;
        reg_wr_o.data  = wb_req_i.wdata;
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            state_q <= ST_IDLE;
            done_q  <= 1'b0;
            ack_q   <= 1'b0;
            data_q  <= '0;
        end
        else
        begin
            case (state_q)
                ST_IDLE:
                begin
                    ack_q  <= 1'b0;
                    data_q <= '0;
                    // nothing written yet in the next transaction
                    done_q <= 1'b0;
                    if (start)
                    begin
                        state_q <= wb_req_i.we ? ST_WRITE : ST_READ;
                    end
                end

                ST_READ,
                ST_WRITE:
                begin
                    if (active)
                    begin
                        // ack held while the master keeps the cycle
                        ack_q  <= 1'b1;
                        // a write also returns the register, old value on the first edge
                        data_q <= rd_data_i;
                        if (state_q == ST_WRITE)
                        begin
                            done_q <= 1'b1;
                        end
                    end
                    else
                    begin
                        // both strobes dropped, end of transaction
                        ack_q   <= 1'b0;
                        data_q  <= '0;
                        state_q <= ST_IDLE;
                    end
                end

                default:
                begin
                    ack_q   <= 1'b0;
                    data_q  <= '0;
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    assign ack_o  = ack_q;
    assign data_o = data_q;

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# builds the testbench with verilator and runs it
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f sources.f --top-module tb_dm -o Vtb_dm
status=$?
if [ "$status" -ne 0 ]; then
    echo "build failed"
    exit "$status"
fi

./obj_dir/Vtb_dm
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed"
    exit "$status"
fi

echo "simulation finished"
exit 0

// ==== sources.f ====
+incdir+.
dm_pkg.sv
dm_wb_slave.sv
dm_regs.sv
dm_abstract_cmd.sv
dm_top.sv
tb_dm.sv

// ==== tb_dm.sv ====
// **************************************************
// directed testbench for dm_top, stops at the first error
// memory model returns pc xor a5a5_0000 one cycle after pc moves
// **************************************************
`timescale 1ns/1ps
`include "dm_settings.svh"

module tb_dm;

    localparam int          NUM_TESTS  = 6;
    localparam int          CLK_PERIOD = 100;
    localparam int          ACK_LIMIT  = 10;
    localparam int          HOLD_CYC   = 6;
    localparam logic [31:0] LFSR_SEED  = 32'h0b92_8832;
    // taps 32 22 2 1
    localparam logic [31:0] LFSR_TAPS  = 32'h8020_0003;
    localparam logic [31:0] MEM_XOR    = 32'hA5A5_0000;

    logic                  clk_i;
    logic                  rst_i;
    logic [`DM_ADDR_W-1:0] addr_i;
    logic                  we_i;
    logic [`DM_BUS_DW-1:0] data_i;
    logic                  cyc_i;
    logic                  stb_i;
    logic [`DM_WORD_W-1:0] instr_i;
    logic [`DM_BUS_DW-1:0] data_o;
    logic                  ack_o;
    logic [`DM_WORD_W-1:0] pc_o;
    logic                  halt_req_o;
    logic                  resume_req_o;

    logic [31:0]           lfsr_q;
    // pc_o changes seen during the last bus transaction
    int                    pc_changes;
    logic [31:0]           pc_seen;
    // address of the last memory command that ran
    logic [31:0]           last_addr;

    dm_top u_dut (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .addr_i       (addr_i),
        .we_i         (we_i),
        .data_i       (data_i),
        .cyc_i        (cyc_i),
        .stb_i        (stb_i),
        .instr_i      (instr_i),
        .data_o       (data_o),
        .ack_o        (ack_o),
        .pc_o         (pc_o),
        .halt_req_o   (halt_req_o),
        .resume_req_o (resume_req_o)
    );

    initial
    begin
        clk_i = 1'b0;
        forever
        begin
            #(CLK_PERIOD / 2) clk_i = ~clk_i;
        end
    end

    // memory word for any address
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return addr ^ MEM_XOR;
    endfunction

    // memory model, answers on the falling edge
    initial
    begin
        instr_i = '0;
        forever
        begin
            @(negedge clk_i);
            instr_i = mem_word(pc_o);
        end
    end

    // limit from the test count, about 40 cycles each
    initial
    begin
        #(NUM_TESTS * 40 * CLK_PERIOD);
        $display("TEST FAIL");
        $fatal(1, "watchdog expired before all tests finished");
    end

    // galois lfsr, one step per bit taken
    function automatic logic [63:0] rand_bits(input int nbits);
        logic [63:0] value;
        logic        bit_out;
        value = '0;
        for (int i = 0; i < nbits; i++)
        begin
            bit_out = lfsr_q[0];
            lfsr_q  = lfsr_q >> 1;
            if (bit_out)
            begin
                lfsr_q = lfsr_q ^ LFSR_TAPS;
            end
            value = {value[62:0], bit_out};
        end
        return value;
    endfunction

    // command word laid out as in the debug spec, access memory format
    function automatic logic [63:0] cmd_word(input logic [7:0] cmdtype,
                                             input logic [2:0] aamsize,
                                             input logic       aamwrite);
        logic [31:0] word;
        word        = '0;
        word[31:24] = cmdtype;
        word[22:20] = aamsize;
        word[16]    = aamwrite;
        return {32'h0, word};
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp)
        begin
            $display("FAILED time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
            $display("TEST FAIL");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic track_pc();
        if (pc_o !== pc_seen)
        begin
            pc_changes++;
        end
        pc_seen = pc_o;
    endtask

    // one bus cycle, entered and left on a falling edge
    // hold keeps the strobes up after ack with the write data flipped
    task automatic wb_access(input logic we, input logic [31:0] addr,
                             input logic [63:0] wdata, input int hold,
                             output logic [63:0] rdata);
        int waited;
        waited     = 0;
        pc_changes = 0;
        pc_seen    = pc_o;
        addr_i     = addr;
        we_i       = we;
        data_i     = wdata;
        cyc_i      = 1'b1;
        stb_i      = 1'b1;
        @(negedge clk_i);
        track_pc();
        while (!ack_o)
        begin
            waited++;
            if (waited >= ACK_LIMIT)
            begin
                $display("TEST FAIL");
                $fatal(1, "no ack within %0d cycles for address %h", ACK_LIMIT, addr);
            end
            @(negedge clk_i);
            track_pc();
        end
        rdata = data_o;
        for (int i = 0; i < hold; i++)
        begin
            // a second write would pick up this value
            data_i = ~wdata;
            @(negedge clk_i);
            track_pc();
        end
        cyc_i = 1'b0;
        stb_i = 1'b0;
        we_i  = 1'b0;
        // one idle cycle
        @(negedge clk_i);
        track_pc();
    endtask

    task automatic wb_write(input logic [31:0] addr, input logic [63:0] wdata);
        logic [63:0] unused;
        wb_access(1'b1, addr, wdata, 0, unused);
    endtask

    task automatic wb_write_held(input logic [31:0] addr, input logic [63:0] wdata);
        logic [63:0] unused;
        wb_access(1'b1, addr, wdata, HOLD_CYC, unused);
    endtask

    task automatic wb_read(input logic [31:0] addr, output logic [63:0] rdata);
        wb_access(1'b0, addr, '0, 0, rdata);
    endtask

    task automatic read_check(input string name, input logic [31:0] addr,
                              input logic [63:0] exp);
        logic [63:0] rdata;
        wb_read(addr, rdata);
        check(name, rdata, exp);
    endtask

    task automatic test_reset();
        check("ack_o", 64'(ack_o), 64'h0);
        check("pc_o", 64'(pc_o), 64'h0);
        check("halt_req_o", 64'(halt_req_o), 64'h0);
        check("resume_req_o", 64'(resume_req_o), 64'h0);
        read_check("data0", `DM_ADDR_DATA0, 64'h0);
        read_check("data1", `DM_ADDR_DATA1, 64'h0);
        read_check("dmcontrol", `DM_ADDR_DMCONTROL, 64'h0);
        read_check("command", `DM_ADDR_COMMAND, 64'h0);
    endtask

    task automatic test_reg_rw();
        logic [63:0] d0;
        logic [63:0] d1;
        logic [63:0] ctl;
        d1  = rand_bits(64);
        ctl = rand_bits(64);
        d0  = rand_bits(32);
        wb_write(`DM_ADDR_DATA1, d1);
        wb_write(`DM_ADDR_DMCONTROL, ctl);
        wb_write(`DM_ADDR_DATA0, d0);
        read_check("data1", `DM_ADDR_DATA1, d1);
        read_check("dmcontrol", `DM_ADDR_DMCONTROL, ctl);
        read_check("data0", `DM_ADDR_DATA0, d0);
        // unmapped address
        read_check("unmapped", 32'h0000_0020, 64'h0);
        wb_write(32'h0000_0020, rand_bits(64));
        read_check("data1", `DM_ADDR_DATA1, d1);
        read_check("dmcontrol", `DM_ADDR_DMCONTROL, ctl);
        read_check("data0", `DM_ADDR_DATA0, d0);
        read_check("command", `DM_ADDR_COMMAND, 64'h0);
    endtask

    task automatic test_run_ctrl();
        wb_write(`DM_ADDR_DMCONTROL, 64'h1 << `DM_HALTREQ_BIT);
        check("halt_req_o", 64'(halt_req_o), 64'h1);
        check("resume_req_o", 64'(resume_req_o), 64'h0);
        wb_write(`DM_ADDR_DMCONTROL, 64'h1 << `DM_RESUMEREQ_BIT);
        check("halt_req_o", 64'(halt_req_o), 64'h0);
        check("resume_req_o", 64'(resume_req_o), 64'h1);
        wb_write(`DM_ADDR_DMCONTROL, 64'h0);
        check("halt_req_o", 64'(halt_req_o), 64'h0);
        check("resume_req_o", 64'(resume_req_o), 64'h0);
    endtask

    task automatic test_mem_cmd();
        logic [63:0] rnd;
        rnd       = rand_bits(64);
        last_addr = rnd[31:0];
        wb_write(`DM_ADDR_DATA1, rnd);
        wb_write(`DM_ADDR_COMMAND, cmd_word(`DM_CMDTYPE_ACCESS_MEM, `DM_AAMSIZE_32, 1'b0));
        check("pc_o", 64'(pc_o), 64'(last_addr));
        repeat (2) @(negedge clk_i);
        read_check("data0", `DM_ADDR_DATA0, {32'h0, mem_word(last_addr)});
        read_check("command", `DM_ADDR_COMMAND,
                   cmd_word(`DM_CMDTYPE_ACCESS_MEM, `DM_AAMSIZE_32, 1'b0));
    endtask

    task automatic test_unsupported();
        logic [63:0] bad_cmd [3];
        bad_cmd[0] = cmd_word(8'h00, `DM_AAMSIZE_32, 1'b0);
        bad_cmd[1] = cmd_word(`DM_CMDTYPE_ACCESS_MEM, `DM_AAMSIZE_32, 1'b1);
        bad_cmd[2] = cmd_word(`DM_CMDTYPE_ACCESS_MEM, 3'd3, 1'b0);
        // new address that a wrongly accepted command would show on pc_o
        wb_write(`DM_ADDR_DATA1, {32'h0, last_addr ^ 32'h0000_0ff0});
        for (int i = 0; i < 3; i++)
        begin
            wb_write(`DM_ADDR_COMMAND, bad_cmd[i]);
            repeat (3) @(negedge clk_i);
            check("pc_o", 64'(pc_o), 64'(last_addr));
            read_check("data0", `DM_ADDR_DATA0, {32'h0, mem_word(last_addr)});
        end
    endtask

    task automatic test_data0_and_hold();
        logic [63:0] v;
        logic [63:0] d;
        v = rand_bits(32);
        wb_write(`DM_ADDR_DATA0, v);
        read_check("data0", `DM_ADDR_DATA0, v);
        d = rand_bits(64);
        if (d[31:0] == pc_o)
        begin
            d[0] = ~d[0];
        end
        // long transactions, flipped data must not land
        wb_write_held(`DM_ADDR_DATA1, d);
        read_check("data1", `DM_ADDR_DATA1, d);
        wb_write_held(`DM_ADDR_COMMAND,
                      cmd_word(`DM_CMDTYPE_ACCESS_MEM, `DM_AAMSIZE_32, 1'b0));
        check("pc_changes", 64'(pc_changes), 64'h1);
        check("pc_o", 64'(pc_o), {32'h0, d[31:0]});
        read_check("command", `DM_ADDR_COMMAND,
                   cmd_word(`DM_CMDTYPE_ACCESS_MEM, `DM_AAMSIZE_32, 1'b0));
        read_check("data0", `DM_ADDR_DATA0, {32'h0, mem_word(d[31:0])});
    endtask

    initial
    begin
        lfsr_q      = LFSR_SEED;
        pc_changes  = 0;
        pc_seen     = '0;
        last_addr   = '0;
        rst_i       = 1'b1;
        addr_i      = '0;
        we_i        = 1'b0;
        data_i      = '0;
        cyc_i       = 1'b0;
        stb_i       = 1'b0;
        repeat (4) @(negedge clk_i);
        rst_i = 1'b0;
        test_reset();
        test_reg_rw();
        test_run_ctrl();
        test_mem_cmd();
        test_unsupported();
        test_data0_and_hold();
        $display("TEST PASS");
        $finish;
    end

endmodule
